/* otp_part_defines.svh */
////////////////////
// OTP partition geometry and widths
////////////////////

`ifndef OTP_PART_DEFINES_SVH
`define OTP_PART_DEFINES_SVH

// Partition placement in the OTP byte space
`define OTP_PART_OFFSET 64
// Partition size in bytes, digest included
`define OTP_PART_SIZE 256

// OTP byte address width
`define OTP_BYTE_ADDR_W 11
// Byte to halfword address shift
`define OTP_ADDR_SHIFT 1
// OTP halfword address width
`define OTP_ADDR_W 10
// Native OTP word width
`define OTP_WORD_W 16
// Number of native words per access, minus one
`define OTP_SIZE_W 2

// Bus window word address width
`define SW_ADDR_W 9
// Digest and OTP read block width
`define DIGEST_W 64

`endif

/* otp_part_pkg.sv */
////////////////////
// OTP partition types
////////////////////

`include "otp_part_defines.svh"

package otp_part_pkg;

  // Partition and macro error codes
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // OTP macro opcodes, only Read is issued here
  typedef enum logic {
    Read    = 1'b0,
    ReadRaw = 1'b1
  } otp_cmd_e;

  // Partition FSM states
  typedef enum logic [2:0] {
    ResetSt,
    InitSt,
    InitWaitSt,
    IdleSt,
    ReadSt,
    ReadWaitSt,
    ErrorSt
  } part_state_e;

  // OTP address source
  typedef enum logic {
    DigestAddrSel = 1'b0,
    DataAddrSel   = 1'b1
  } addr_sel_e;

  typedef struct packed {
    logic read_lock;
    logic write_lock;
  } part_access_t;

  // Command towards the OTP macro
  typedef struct packed {
    logic                     req;
    otp_cmd_e                 cmd;
    logic [`OTP_SIZE_W-1:0]   size;
    logic [`OTP_ADDR_W-1:0]   addr;
  } otp_req_t;

  // Response from the OTP macro
  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`DIGEST_W-1:0]   rdata;
    otp_err_e               err;
  } otp_rsp_t;

  // Response towards the bus adapter
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [1:0]  rerror;
    logic [31:0] rdata;
  } tl_rsp_t;

endpackage

/* otp_part_addr.sv */
////////////////////
// Partition address unit
////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_addr (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [`SW_ADDR_W-1:0]         tl_addr_i,
  input  logic                          gnt_i,
  input  otp_part_pkg::addr_sel_e       addr_sel_i,
  output logic                          in_range_o,
  output logic [`OTP_ADDR_W-1:0]        otp_addr_o,
  output logic [`OTP_SIZE_W-1:0]        otp_size_o
);

  localparam int ByteW = `OTP_BYTE_ADDR_W;
  localparam int SizeW = `OTP_SIZE_W;

  // Partition bounds in bytes, one extra bit so the end fits
  localparam int unsigned PartOffsetInt = `OTP_PART_OFFSET;
  localparam int unsigned PartEndInt    = `OTP_PART_OFFSET + `OTP_PART_SIZE;
  // Digest sits in the last block of the partition
  localparam int unsigned DigestOffInt  = PartEndInt - `DIGEST_W / 8;
  // Native words per access minus one
  localparam int unsigned DigestSizeInt = `DIGEST_W / `OTP_WORD_W - 1;
  localparam int unsigned DataSizeInt   = 32 / `OTP_WORD_W - 1;

  localparam logic [ByteW:0]   PartOffset   = PartOffsetInt[ByteW:0];
  localparam logic [ByteW:0]   PartEnd      = PartEndInt[ByteW:0];
  localparam logic [ByteW-1:0] DigestOffset = DigestOffInt[ByteW-1:0];
  localparam logic [SizeW-1:0] DigestSize   = DigestSizeInt[SizeW-1:0];
  localparam logic [SizeW-1:0] DataSize     = DataSizeInt[SizeW-1:0];

  logic [`SW_ADDR_W-1:0] addr_q;
  logic [ByteW-1:0]      byte_addr;
  logic [ByteW-1:0]      addr_calc;

  // Word address captured with the bus grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (gnt_i) begin
      addr_q <= tl_addr_i;
    end
  end

  // Bus window is word addressed
  assign byte_addr = {addr_q, 2'b00};

  // Lower bound inclusive, end exclusive
  assign in_range_o = ({1'b0, byte_addr} >= PartOffset) &&
                      ({1'b0, byte_addr} < PartEnd);

  always_comb begin
    if (addr_sel_i == otp_part_pkg::DigestAddrSel) begin
      addr_calc  = DigestOffset;
      otp_size_o = DigestSize;
    end else begin
      addr_calc  = byte_addr;
      otp_size_o = DataSize;
    end
  end

  // OTP works on 16 bit halfwords
  assign otp_addr_o = addr_calc[ByteW-1:`OTP_ADDR_SHIFT];

endmodule

/* otp_part_lock.sv */
////////////////////
// Digest register and locks
////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_lock (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          digest_we_i,
  input  logic [`DIGEST_W-1:0]          rdata_i,
  input  logic                          init_done_i,
  input  otp_part_pkg::part_access_t    access_i,
  output logic [`DIGEST_W-1:0]          digest_o,
  output otp_part_pkg::part_access_t    access_o
);

  logic [`DIGEST_W-1:0] digest_q;
  logic                 init_locked;
  logic                 digest_locked;

  ////////////////////
  // Digest register
  ////////////////////

  // Loaded once from the init read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (digest_we_i) begin
      digest_q <= rdata_i;
    end
  end

  assign digest_o = digest_q;

  ////////////////////
  // Access control
  ////////////////////

  // Locked until the digest has been read out
  assign init_locked = ~init_done_i;

  // A programmed digest seals the partition
  assign digest_locked = |digest_q;

  // Software lock is only ever tightened here
  always_comb begin
    access_o.read_lock  = access_i.read_lock | init_locked | digest_locked;
    access_o.write_lock = access_i.write_lock | init_locked | digest_locked;
  end

endmodule

/* otp_part_fsm.sv */
////////////////////
// Partition FSM
////////////////////

`timescale 1ns/1ps

module otp_part_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        init_req_i,
  input  logic                        escalate_en_i,
  input  logic                        tl_req_i,
  input  otp_part_pkg::otp_rsp_t      otp_rsp_i,
  input  logic                        in_range_i,
  input  logic                        read_lock_i,
  output logic                        otp_req_o,
  output otp_part_pkg::otp_cmd_e      otp_cmd_o,
  output otp_part_pkg::addr_sel_e     addr_sel_o,
  output otp_part_pkg::tl_rsp_t       tl_rsp_o,
  output logic                        gnt_o,
  output logic                        digest_we_o,
  output logic                        init_done_o,
  output otp_part_pkg::otp_err_e      error_o,
  output logic                        fsm_err_o
);

  otp_part_pkg::part_state_e state_d, state_q;
  otp_part_pkg::otp_err_e    error_d, error_q;
  logic                      otp_ok;
  // Bus error still owed in ErrorSt
  logic                      pend_err_d, pend_err_q;

  // Integrity is always on for this partition
  assign otp_cmd_o = otp_part_pkg::Read;
  assign error_o   = error_q;
  assign gnt_o     = tl_rsp_o.gnt;

  // Only correctable ECC errors are survivable
  assign otp_ok = otp_rsp_i.err inside {otp_part_pkg::NoError,
                                        otp_part_pkg::MacroEccCorrError};

  always_comb begin
    state_d     = state_q;
    error_d     = error_q;
    pend_err_d  = 1'b0;
    otp_req_o   = 1'b0;
    addr_sel_o  = otp_part_pkg::DigestAddrSel;
    tl_rsp_o    = '0;
    digest_we_o = 1'b0;
    init_done_o = 1'b0;
    fsm_err_o   = 1'b0;

    unique case (state_q)
      // Wait for the init pulse
      otp_part_pkg::ResetSt: begin
        if (init_req_i) begin
          state_d = otp_part_pkg::InitSt;
        end
      end
      // Digest read, hold req until granted
      otp_part_pkg::InitSt: begin
        otp_req_o = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = otp_part_pkg::InitWaitSt;
        end
      end
      // Capture digest, fatal errors are terminal
      otp_part_pkg::InitWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          digest_we_o = 1'b1;
          if (otp_ok) begin
            state_d = otp_part_pkg::IdleSt;
            if (otp_rsp_i.err != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
          end else begin
            state_d = otp_part_pkg::ErrorSt;
            error_d = otp_rsp_i.err;
          end
        end
      end
      // Grant bus requests, soft errors are cleared here
      otp_part_pkg::IdleSt: begin
        init_done_o = 1'b1;
        if (tl_req_i) begin
          tl_rsp_o.gnt = 1'b1;
          error_d      = otp_part_pkg::NoError;
          state_d      = otp_part_pkg::ReadSt;
        end
      end
      // Bounds and lock check, then issue the OTP read
      otp_part_pkg::ReadSt: begin
        init_done_o = 1'b1;
        if (in_range_i && !read_lock_i) begin
          otp_req_o  = 1'b1;
          addr_sel_o = otp_part_pkg::DataAddrSel;
          if (otp_rsp_i.gnt) begin
            state_d = otp_part_pkg::ReadWaitSt;
          end
        end else begin
          // Bus error only, partition stays usable
          tl_rsp_o.rvalid = 1'b1;
          tl_rsp_o.rerror = 2'b11;
          error_d         = otp_part_pkg::AccessError;
          state_d         = otp_part_pkg::IdleSt;
        end
      end
      // Forward the OTP response to the bus
      otp_part_pkg::ReadWaitSt: begin
        init_done_o = 1'b1;
        if (otp_rsp_i.rvalid) begin
          tl_rsp_o.rvalid = 1'b1;
          if (otp_ok) begin
            state_d = otp_part_pkg::IdleSt;
            if (otp_rsp_i.err != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
          end else begin
            tl_rsp_o.rerror = 2'b11;
            error_d         = otp_rsp_i.err;
            state_d         = otp_part_pkg::ErrorSt;
          end
        end
      end
      // Terminal, every request gets a bus error
      otp_part_pkg::ErrorSt: begin
        if (error_q == otp_part_pkg::NoError) begin
          error_d = otp_part_pkg::FsmStateError;
        end
        if (pend_err_q) begin
          tl_rsp_o.rvalid = 1'b1;
          tl_rsp_o.rerror = 2'b11;
        end else if (tl_req_i) begin
          tl_rsp_o.gnt = 1'b1;
          pend_err_d   = 1'b1;
        end
      end
      // Unreachable encoding
      default: begin
        state_d   = otp_part_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) begin
      state_d   = otp_part_pkg::ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == otp_part_pkg::NoError) begin
        error_d = otp_part_pkg::FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= otp_part_pkg::ResetSt;
      error_q    <= otp_part_pkg::NoError;
      pend_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      pend_err_q <= pend_err_d;
    end
  end

endmodule

/* otp_part_unbuf.sv */
////////////////////
// Unbuffered OTP partition
////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_unbuf (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          init_req_i,
  input  logic                          escalate_en_i,
  input  otp_part_pkg::part_access_t    access_i,
  input  logic                          tl_req_i,
  input  logic [`SW_ADDR_W-1:0]         tl_addr_i,
  input  otp_part_pkg::otp_rsp_t        otp_i,
  output logic                          init_done_o,
  output otp_part_pkg::otp_err_e        error_o,
  output logic                          fsm_err_o,
  output otp_part_pkg::part_access_t    access_o,
  output logic [`DIGEST_W-1:0]          digest_o,
  output otp_part_pkg::tl_rsp_t         tl_rsp_o,
  output otp_part_pkg::otp_req_t        otp_o
);

  logic                       gnt;
  logic                       in_range;
  logic                       digest_we;
  otp_part_pkg::addr_sel_e    addr_sel;
  otp_part_pkg::tl_rsp_t      fsm_rsp;
  logic                       otp_req;
  otp_part_pkg::otp_cmd_e     otp_cmd;
  logic [`OTP_ADDR_W-1:0]     otp_addr;
  logic [`OTP_SIZE_W-1:0]     otp_size;

  // Bounds check and OTP address
  otp_part_addr u_addr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tl_addr_i  (tl_addr_i),
    .gnt_i      (gnt),
    .addr_sel_i (addr_sel),
    .in_range_o (in_range),
    .otp_addr_o (otp_addr),
    .otp_size_o (otp_size)
  );

  // Digest register and lock merge
  otp_part_lock u_lock (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .digest_we_i (digest_we),
    .rdata_i     (otp_i.rdata),
    .init_done_i (init_done_o),
    .access_i    (access_i),
    .digest_o    (digest_o),
    .access_o    (access_o)
  );

  otp_part_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_req_i    (init_req_i),
    .escalate_en_i (escalate_en_i),
    .tl_req_i      (tl_req_i),
    .otp_rsp_i     (otp_i),
    .in_range_i    (in_range),
    .read_lock_i   (access_o.read_lock),
    .otp_req_o     (otp_req),
    .otp_cmd_o     (otp_cmd),
    .addr_sel_o    (addr_sel),
    .tl_rsp_o      (fsm_rsp),
    .gnt_o         (gnt),
    .digest_we_o   (digest_we),
    .init_done_o   (init_done_o),
    .error_o       (error_o),
    .fsm_err_o     (fsm_err_o)
  );

  assign otp_o = '{req: otp_req, cmd: otp_cmd, size: otp_size, addr: otp_addr};

  // Strobes from the FSM, data only on a clean response
  always_comb begin
    tl_rsp_o       = fsm_rsp;
    tl_rsp_o.rdata = (fsm_rsp.rvalid && fsm_rsp.rerror == 2'b00) ? otp_i.rdata[31:0] : '0;
  end

endmodule

/* tb_otp_part_unbuf.sv */
////////////////////
// OTP partition testbench
////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module tb_otp_part_unbuf;

  localparam int WaitLimit = 200;
  // Digest halfword address from the partition layout
  localparam int DigestHw = (`OTP_PART_OFFSET + `OTP_PART_SIZE - `DIGEST_W / 8) >> `OTP_ADDR_SHIFT;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       init_req_i;
  logic                       escalate_en_i;
  otp_part_pkg::part_access_t access_i;
  logic                       tl_req_i;
  logic [`SW_ADDR_W-1:0]      tl_addr_i;
  otp_part_pkg::otp_rsp_t     otp_i;
  logic                       init_done_o;
  otp_part_pkg::otp_err_e     error_o;
  logic                       fsm_err_o;
  otp_part_pkg::part_access_t access_o;
  logic [`DIGEST_W-1:0]       digest_o;
  otp_part_pkg::tl_rsp_t      tl_rsp_o;
  otp_part_pkg::otp_req_t     otp_o;

  // Macro model state
  logic [15:0]            otp_mem [512];
  integer                 stim_seed;
  integer                 macro_seed;
  int                     gnt_wait;
  int                     rsp_wait;
  otp_part_pkg::otp_err_e rsp_err;
  logic [`OTP_ADDR_W-1:0] gnt_addr;
  logic [`OTP_SIZE_W-1:0] gnt_size;
  otp_part_pkg::otp_cmd_e gnt_cmd;
  // Reference model state
  otp_part_pkg::otp_err_e exp_err;
  logic                   in_error;
  logic                   digest_set;

  otp_part_unbuf DUT (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////
  // OTP macro model
  ////////////////////

  // Halfwords little endian, size+1 of them
  function automatic logic [63:0] read_block(input logic [9:0] addr, input logic [1:0] size);
    logic [63:0] blk;
    blk = '0;
    for (int i = 0; i <= int'(size); i++) begin
      blk[16*i +: 16] = otp_mem[(int'(addr) + i) % 512];
    end
    return blk;
  endfunction

  // Grant after 0..3 cycles, answer 1..4 cycles after the grant
  always @(negedge clk_i) begin
    otp_i = '0;
    if (!rst_ni) begin
      gnt_wait = -1;
      rsp_wait = -1;
    end else if (rsp_wait > 0) begin
      rsp_wait--;
    end else if (rsp_wait == 0) begin
      otp_i.rvalid = 1'b1;
      otp_i.rdata  = read_block(gnt_addr, gnt_size);
      otp_i.err    = rsp_err;
      rsp_wait     = -1;
    end else if (otp_o.req) begin
      if (gnt_wait < 0) begin
        gnt_wait = $random(macro_seed) & 3;
      end
      if (gnt_wait == 0) begin
        otp_i.gnt = 1'b1;
        gnt_addr  = otp_o.addr;
        gnt_size  = otp_o.size;
        gnt_cmd   = otp_o.cmd;
        rsp_wait  = $random(macro_seed) & 3;
        gnt_wait  = -1;
      end else begin
        gnt_wait--;
      end
    end
  end

  ////////////////////
  // Checking
  ////////////////////

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch in %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    abort_run();
  endtask

  // Word window in bytes, offset inclusive and end exclusive
  function automatic logic addr_in_range(input logic [8:0] waddr);
    int byte_addr;
    byte_addr = int'(waddr) * 4;
    return (byte_addr >= `OTP_PART_OFFSET) && (byte_addr < `OTP_PART_OFFSET + `OTP_PART_SIZE);
  endfunction

  function automatic logic [31:0] expect_word(input logic [8:0] waddr);
    int hw;
    hw = int'(waddr) * 2;
    return {otp_mem[hw+1], otp_mem[hw]};
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni        = 1'b0;
    init_req_i    = 1'b0;
    escalate_en_i = 1'b0;
    tl_req_i      = 1'b0;
    tl_addr_i     = '0;
    access_i      = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_value("reset init_done", 0, init_done_o);
    check_value("reset otp req", 0, otp_o.req);
    check_value("reset bus strobes", 0, {tl_rsp_o.gnt, tl_rsp_o.rvalid});
    check_value("reset digest", 0, digest_o);
    check_value("reset error", otp_part_pkg::NoError, error_o);
    check_value("reset locks", 2'b11, access_o);
  endtask

  task automatic init_partition(input string name, input otp_part_pkg::otp_err_e reply_err);
    int          cnt;
    logic [63:0] exp_digest;
    check_value({name, " locks before init"}, 2'b11, access_o);
    rsp_err = reply_err;
    @(negedge clk_i);
    init_req_i = 1'b1;
    @(negedge clk_i);
    init_req_i = 1'b0;
    cnt = 0;
    @(posedge clk_i);
    while (!init_done_o) begin
      cnt++;
      if (cnt > WaitLimit) report_timeout({name, " init done"});
      @(posedge clk_i);
    end
    exp_digest = {otp_mem[DigestHw+3], otp_mem[DigestHw+2], otp_mem[DigestHw+1], otp_mem[DigestHw]};
    check_value({name, " digest addr"}, DigestHw, gnt_addr);
    check_value({name, " digest size"}, 3, gnt_size);
    check_value({name, " digest cmd"}, otp_part_pkg::Read, gnt_cmd);
    check_value({name, " digest"}, exp_digest, digest_o);
    check_value({name, " error"}, reply_err, error_o);
    check_value({name, " locks"}, digest_set ? 2'b11 : 2'b00, access_o);
    exp_err  = reply_err;
    in_error = 1'b0;
  endtask

  task automatic bus_read(input string name, input logic [8:0] waddr, input logic lock,
                          input otp_part_pkg::otp_err_e reply_err);
    int          cnt;
    logic        accept;
    logic        was_error;
    logic [1:0]  exp_rerror;
    logic [31:0] exp_rdata;
    was_error  = in_error;
    accept     = !in_error && addr_in_range(waddr) && !lock && !digest_set;
    exp_rerror = 2'b11;
    exp_rdata  = '0;
    rsp_err    = reply_err;
    @(negedge clk_i);
    tl_req_i           = 1'b1;
    tl_addr_i          = waddr;
    access_i.read_lock = lock;
    cnt = 0;
    @(posedge clk_i);
    while (!tl_rsp_o.gnt) begin
      cnt++;
      if (cnt > WaitLimit) report_timeout({name, " bus grant"});
      @(posedge clk_i);
    end
    // Idle and error states both grant in the request cycle
    check_value({name, " grant latency"}, 0, cnt);
    @(negedge clk_i);
    tl_req_i = 1'b0;
    cnt = 0;
    @(posedge clk_i);
    if (!was_error) check_value({name, " code cleared"}, otp_part_pkg::NoError, error_o);
    while (!tl_rsp_o.rvalid) begin
      cnt++;
      if (cnt > WaitLimit) report_timeout({name, " bus rvalid"});
      @(posedge clk_i);
    end
    if (!accept) check_value({name, " error latency"}, 0, cnt);
    // Reference model update
    if (!accept) begin
      // Code stays frozen once terminal
      if (!was_error) exp_err = otp_part_pkg::AccessError;
    end else if (reply_err inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError}) begin
      exp_rerror = 2'b00;
      exp_rdata  = expect_word(waddr);
      exp_err    = reply_err;
    end else begin
      exp_err  = reply_err;
      in_error = 1'b1;
    end
    if (accept) begin
      check_value({name, " otp addr"}, waddr * 2, gnt_addr);
      check_value({name, " otp size"}, 1, gnt_size);
    end
    check_value({name, " rerror"}, exp_rerror, tl_rsp_o.rerror);
    check_value({name, " rdata"}, exp_rdata, tl_rsp_o.rdata);
    @(posedge clk_i);
    check_value({name, " error code"}, exp_err, error_o);
  endtask

  task automatic escalate();
    @(negedge clk_i);
    escalate_en_i = 1'b1;
    @(posedge clk_i);
    check_value("fsm_err pulse", 1, fsm_err_o);
    @(negedge clk_i);
    escalate_en_i = 1'b0;
    if (exp_err == otp_part_pkg::NoError) exp_err = otp_part_pkg::FsmStateError;
    in_error = 1'b1;
    @(posedge clk_i);
    check_value("fsm_err release", 0, fsm_err_o);
    check_value("escalation code", exp_err, error_o);
  endtask

  // 0 random reads, 1 sealed digest, 2 and 3 fatal macro errors, 4 escalation
  task automatic run_session(input int sel);
    logic [31:0] r;
    apply_reset();
    for (int i = 0; i < 512; i++) begin
      otp_mem[i] = 16'($random(stim_seed));
    end
    // Only the sealed session keeps its random digest
    if (sel != 1) begin
      for (int i = DigestHw; i < DigestHw + 4; i++) begin
        otp_mem[i] = '0;
      end
    end
    digest_set = |{otp_mem[DigestHw+3], otp_mem[DigestHw+2], otp_mem[DigestHw+1],
                   otp_mem[DigestHw]};
    init_partition($sformatf("init%0d", sel),
                   (sel == 0) ? otp_part_pkg::MacroEccCorrError : otp_part_pkg::NoError);
    if (sel < 2) begin
      for (int n = 0; n < 24; n++) begin
        r = $random(stim_seed);
        bus_read($sformatf("read%0d_%0d", sel, n), 9'd12 + {2'b00, r[6:0]}, r[10:8] == 3'b000,
                 r[11] ? otp_part_pkg::MacroEccCorrError : otp_part_pkg::NoError);
      end
    end else begin
      bus_read($sformatf("clean%0d_a", sel), 9'd20, 1'b0, otp_part_pkg::NoError);
      bus_read($sformatf("clean%0d_b", sel), 9'd70, 1'b0, otp_part_pkg::NoError);
      if (sel == 4) begin
        escalate();
      end else begin
        bus_read($sformatf("fatal%0d", sel), 9'd33, 1'b0,
                 (sel == 2) ? otp_part_pkg::MacroEccUncorrError : otp_part_pkg::MacroError);
      end
      for (int n = 0; n < 4; n++) begin
        r = $random(stim_seed);
        bus_read($sformatf("terminal%0d_%0d", sel, n), 9'd12 + {2'b00, r[6:0]}, r[8],
                 otp_part_pkg::NoError);
      end
    end
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    init_req_i    = 1'b0;
    escalate_en_i = 1'b0;
    access_i      = '0;
    tl_req_i      = 1'b0;
    tl_addr_i     = '0;
    otp_i         = '0;
    stim_seed     = 32'h5209;
    macro_seed    = 32'h5209;
    rsp_err       = otp_part_pkg::NoError;
    exp_err       = otp_part_pkg::NoError;
    in_error      = 1'b0;
    digest_set    = 1'b0;
    for (int s = 0; s < 5; s++) begin
      run_session(s);
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* otp_part_unbuf.f */
+incdir+.
otp_part_pkg.sv
otp_part_addr.sv
otp_part_lock.sv
otp_part_fsm.sv
otp_part_unbuf.sv
tb_otp_part_unbuf.sv

/* Bender.yml */
package:
  name: otp_part_unbuf

export_include_dirs:
  - .

sources:
  - otp_part_pkg.sv
  - otp_part_addr.sv
  - otp_part_lock.sv
  - otp_part_fsm.sv
  - otp_part_unbuf.sv
  - target: simulation
    files:
      - tb_otp_part_unbuf.sv
